// ==== verilog/trace_cfg.svh ====
// Sizes shared by the trace monitor RTL and its testbench
// TRACE_FIFO_DEPTH must stay a power of two, since the FIFO pointers wrap freely
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

`define TRACE_PC_W        32   // Instruction address width
`define TRACE_SEQ_W       8    // Sequence tag, wraps after 256 fetches

// Free running cycle stamp, differences are taken modulo 2**16
`define TRACE_CYC_W       16

`define TRACE_STALL_W     4    // Per instruction stall count, saturates at 15

`define TRACE_FIFO_DEPTH  8    // Retire record entries
`define TRACE_CNT_W       16   // Statistics and drop counters, wrap

`endif

// ==== verilog/trace_pkg.sv ====
// Types shared by the trace monitor, stage encoding follows pipeline order
// EMPTY marks a slot with no instruction in it

package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stage of a tracked instruction
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    EMPTY,      // Slot holds nothing
    FETCH,      // IF
    DECODE,     // ID
    EXECUTE,    // EX
    MEMORY,     // MEM
    WRITEBACK   // WB, retires at the next edge
  } stage_t;

  // Event kinds seen by the statistics block
  typedef enum logic [1:0] {EVT_NONE, EVT_RETIRE, EVT_FLUSH, EVT_STALL} stat_evt_t;

endpackage

// ==== verilog/pipe_stage_tracker.sv ====
// Follows each fetched instruction through IF..WB under stall and flush
// Flush wins over stall; EX and later always advance, WB retires every edge
`timescale 1ns/1ps
`include "trace_cfg.svh"

module pipe_stage_tracker import trace_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        fetch_valid,    // Sampled on rising edge
  input  logic [`TRACE_PC_W-1:0]      fetch_pc,
  input  logic                        stall,          // Level, holds IF and ID
  input  logic                        flush,          // One cycle pulse, kills IF and ID
  output logic                        slot_valid [5],
  output logic [`TRACE_SEQ_W-1:0]     slot_seq [5],
  output stage_t                      slot_stage [5],
  output logic                        retire_we,      // High while WB holds an instruction
  output logic [`TRACE_SEQ_W-1:0]     rec_seq,
  output logic [`TRACE_PC_W-1:0]      rec_pc,
  output logic [`TRACE_CYC_W-1:0]     rec_fetch_cyc,
  output logic [`TRACE_CYC_W-1:0]     rec_retire_cyc,
  output logic [`TRACE_STALL_W-1:0]   rec_stalls,
  output logic                        evt_retire,
  output logic [1:0]                  evt_flush_n,    // Valid slots killed this cycle
  output logic                        evt_stall
);

  // Slot index per stage, IF is the youngest
  localparam int IF_S  = 0;
  localparam int ID_S  = 1;
  localparam int EX_S  = 2;
  localparam int MEM_S = 3;
  localparam int WB_S  = 4;

  logic                      valid_q [5];
  logic [`TRACE_SEQ_W-1:0]   seq_q   [5];
  logic [`TRACE_PC_W-1:0]    pc_q    [5];
  logic [`TRACE_CYC_W-1:0]   fcyc_q  [5];   // Cycle stamp at acceptance
  logic [`TRACE_STALL_W-1:0] stl_q   [5];   // Stalled cycles so far

  logic [`TRACE_SEQ_W-1:0]   seq_cnt;       // Next tag to hand out
  logic [`TRACE_CYC_W-1:0]   cyc_cnt;       // Free running cycle stamp
  logic                      stalled;       // Stall that actually holds IF/ID
  logic                      accept;        // New fetch enters IF this edge

  // Saturating add of one stall cycle
  function automatic logic [`TRACE_STALL_W-1:0] sat_inc(
    input logic [`TRACE_STALL_W-1:0] v
  );
    return (v == '1) ? v : v + 1'b1;
  endfunction

  // Slot index to stage name
  function automatic stage_t stage_of(input int idx);
    case (idx)
      IF_S:    return FETCH;
      ID_S:    return DECODE;
      EX_S:    return EXECUTE;
      MEM_S:   return MEMORY;
      WB_S:    return WRITEBACK;
      default: return EMPTY;
    endcase
  endfunction

  assign stalled = stall & ~flush;                // Flush has priority
  assign accept  = fetch_valid & (~stall | flush);

  ////////////////////////////////////////////////////////////////////////////
  // Control state: slot valids, tag and cycle counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 5; i++) begin
        valid_q[i] <= 1'b0;
      end
      seq_cnt <= '0;
      cyc_cnt <= '0;
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;               // Every edge, wraps
      if (accept)
        seq_cnt <= seq_cnt + 1'b1;             // Only on acceptance

      valid_q[WB_S]  <= valid_q[MEM_S];        // WB entry leaves, MEM replaces it
      valid_q[MEM_S] <= valid_q[EX_S];
      valid_q[EX_S]  <= valid_q[ID_S] & ~stall & ~flush;   // Bubble on stall or flush

      // ID: killed, held, or refilled from IF
      if (flush)
        valid_q[ID_S] <= 1'b0;
      else if (!stall)
        valid_q[ID_S] <= valid_q[IF_S];

      // IF: new fetch, kill, hold, or drains into ID
      if (accept)
        valid_q[IF_S] <= 1'b1;
      else if (!stalled)
        valid_q[IF_S] <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload per slot, meaningful only where the valid is set
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    // EX..WB shift every edge
    for (int i = WB_S; i > ID_S; i--) begin
      seq_q[i]  <= seq_q[i-1];
      pc_q[i]   <= pc_q[i-1];
      fcyc_q[i] <= fcyc_q[i-1];
      stl_q[i]  <= stl_q[i-1];
    end

    if (stalled) begin
      stl_q[ID_S] <= sat_inc(stl_q[ID_S]);    // Held instruction counts the cycle
    end else begin
      seq_q[ID_S]  <= seq_q[IF_S];
      pc_q[ID_S]   <= pc_q[IF_S];
      fcyc_q[ID_S] <= fcyc_q[IF_S];
      stl_q[ID_S]  <= stl_q[IF_S];
    end

    if (accept) begin
      seq_q[IF_S]  <= seq_cnt;
      pc_q[IF_S]   <= fetch_pc;
      fcyc_q[IF_S] <= cyc_cnt;                 // Stamp of the accepting edge
      stl_q[IF_S]  <= '0;
    end else if (stalled) begin
      stl_q[IF_S]  <= sat_inc(stl_q[IF_S]);
    end
  end

  // Slot view for the lookup
  always_comb begin
    for (int i = 0; i < 5; i++) begin
      slot_valid[i] = valid_q[i];
      slot_seq[i]   = seq_q[i];
      slot_stage[i] = valid_q[i] ? stage_of(i) : EMPTY;
    end
  end

  // Retire record straight from the WB slot, written as WB clears
  assign retire_we      = valid_q[WB_S];
  assign rec_seq        = seq_q[WB_S];
  assign rec_pc         = pc_q[WB_S];
  assign rec_fetch_cyc  = fcyc_q[WB_S];
  assign rec_retire_cyc = cyc_cnt;             // Stamp of the leaving edge
  assign rec_stalls     = stl_q[WB_S];

  // Statistics strobes
  assign evt_retire  = valid_q[WB_S];
  assign evt_flush_n = flush ? ({1'b0, valid_q[IF_S]} + {1'b0, valid_q[ID_S]}) : 2'd0;
  assign evt_stall   = stalled & (valid_q[IF_S] | valid_q[ID_S]);

endmodule

// ==== verilog/stage_lookup.sv ====
// Combinational tag search over the tracker slots, no latency
// After the tag wraps two slots may match, the youngest one is reported
`timescale 1ns/1ps
`include "trace_cfg.svh"

module stage_lookup import trace_pkg::*; (
  input  logic                     slot_valid [5],
  input  logic [`TRACE_SEQ_W-1:0]  slot_seq [5],
  input  stage_t                   slot_stage [5],
  input  logic [`TRACE_SEQ_W-1:0]  query_seq,      // Tag to find
  output logic                     query_hit,
  output stage_t                   query_stage     // EMPTY on a miss
);

  ////////////////////////////////////////////////////////////////////////////
  // Priority search, oldest first so a younger match overrides it
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    query_hit   = 1'b0;
    query_stage = EMPTY;
    for (int i = 4; i >= 0; i--) begin
      // Slot 0 is IF, so the last hit in this order is the youngest
      if (slot_valid[i] && (slot_seq[i] == query_seq)) begin
        query_hit   = 1'b1;
        query_stage = slot_stage[i];
      end
    end
  end

endmodule

// ==== verilog/retire_fifo.sv ====
// Show-ahead FIFO of retire records, head valid whenever empty is low
// A write into a full FIFO is dropped and counted, unless a pop frees a slot
`timescale 1ns/1ps
`include "trace_cfg.svh"

module retire_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        we,
  input  logic [`TRACE_SEQ_W-1:0]     wr_seq,
  input  logic [`TRACE_PC_W-1:0]      wr_pc,
  input  logic [`TRACE_CYC_W-1:0]     wr_fetch_cyc,
  input  logic [`TRACE_CYC_W-1:0]     wr_retire_cyc,
  input  logic [`TRACE_STALL_W-1:0]   wr_stalls,
  input  logic                        rd_en,          // Ignored while empty
  output logic                        empty,
  output logic [`TRACE_SEQ_W-1:0]     rd_seq,
  output logic [`TRACE_PC_W-1:0]      rd_pc,
  output logic [`TRACE_CYC_W-1:0]     rd_fetch_cyc,
  output logic [`TRACE_CYC_W-1:0]     rd_retire_cyc,
  output logic [`TRACE_STALL_W-1:0]   rd_stalls,
  output logic [`TRACE_CNT_W-1:0]     drop_count
);

  localparam int AW = $clog2(`TRACE_FIFO_DEPTH);

  logic [`TRACE_SEQ_W-1:0]   seq_mem  [`TRACE_FIFO_DEPTH];
  logic [`TRACE_PC_W-1:0]    pc_mem   [`TRACE_FIFO_DEPTH];
  logic [`TRACE_CYC_W-1:0]   fcyc_mem [`TRACE_FIFO_DEPTH];
  logic [`TRACE_CYC_W-1:0]   rcyc_mem [`TRACE_FIFO_DEPTH];
  logic [`TRACE_STALL_W-1:0] stl_mem  [`TRACE_FIFO_DEPTH];

  logic [AW-1:0] wr_ptr;       // Wraps at depth
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;         // 0..depth
  logic          full;
  logic          pop;
  logic          push;

  assign empty = (fill == '0);
  assign full  = (fill == (AW+1)'(`TRACE_FIFO_DEPTH));
  assign pop   = rd_en & ~empty;
  assign push  = we & (~full | pop);           // Pop frees the slot this edge

  ////////////////////////////////////////////////////////////////////////////
  // Pointers, fill level and drop counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      drop_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        fill <= fill + 1'b1;
      else if (pop && !push)
        fill <= fill - 1'b1;
      if (we && !push)
        drop_count <= drop_count + 1'b1;       // Record lost, pipeline keeps going
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      seq_mem[wr_ptr]  <= wr_seq;
      pc_mem[wr_ptr]   <= wr_pc;
      fcyc_mem[wr_ptr] <= wr_fetch_cyc;
      rcyc_mem[wr_ptr] <= wr_retire_cyc;
      stl_mem[wr_ptr]  <= wr_stalls;
    end
  end

  // Head shown without a read cycle
  assign rd_seq        = seq_mem[rd_ptr];
  assign rd_pc         = pc_mem[rd_ptr];
  assign rd_fetch_cyc  = fcyc_mem[rd_ptr];
  assign rd_retire_cyc = rcyc_mem[rd_ptr];
  assign rd_stalls     = stl_mem[rd_ptr];

endmodule

// ==== verilog/trace_stats.sv ====
// Wrapping event counters, each updates at the edge after its strobe
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_stats import trace_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     evt_retire,
  input  logic [1:0]               evt_flush_n,    // 0..2 killed this cycle
  input  logic                     evt_stall,
  output logic [`TRACE_CNT_W-1:0]  retired_count,
  output logic [`TRACE_CNT_W-1:0]  flushed_count,
  output logic [`TRACE_CNT_W-1:0]  stall_count
);

  // One decoded kind per strobe, strobes may coincide
  stat_evt_t kind_ret;
  stat_evt_t kind_fl;
  stat_evt_t kind_st;

  assign kind_ret = evt_retire           ? EVT_RETIRE : EVT_NONE;
  assign kind_fl  = (evt_flush_n != '0)  ? EVT_FLUSH  : EVT_NONE;
  assign kind_st  = evt_stall            ? EVT_STALL  : EVT_NONE;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retired_count <= '0;
      flushed_count <= '0;
      stall_count   <= '0;
    end else begin
      if (kind_ret == EVT_RETIRE)
        retired_count <= retired_count + 1'b1;
      if (kind_fl == EVT_FLUSH)
        flushed_count <= flushed_count + `TRACE_CNT_W'(evt_flush_n);   // Adds the kill count
      if (kind_st == EVT_STALL)
        stall_count <= stall_count + 1'b1;
    end
  end

endmodule

// ==== verilog/pipe_trace_top.sv ====
// Trace monitor top, fetch/stall/flush are plain strobes with no handshake
// Records pop with rd_en; a full FIFO drops new records into drop_count
`timescale 1ns/1ps
`include "trace_cfg.svh"

module pipe_trace_top import trace_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       fetch_valid,
  input  logic [`TRACE_PC_W-1:0]     fetch_pc,
  input  logic                       stall,
  input  logic                       flush,
  input  logic [`TRACE_SEQ_W-1:0]    query_seq,
  input  logic                       rd_en,
  output logic                       query_hit,
  output stage_t                     query_stage,
  output logic                       ret_empty,
  output logic [`TRACE_SEQ_W-1:0]    ret_seq,
  output logic [`TRACE_PC_W-1:0]     ret_pc,
  output logic [`TRACE_CYC_W-1:0]    ret_fetch_cyc,
  output logic [`TRACE_CYC_W-1:0]    ret_retire_cyc,
  output logic [`TRACE_STALL_W-1:0]  ret_stalls,
  output logic [`TRACE_CNT_W-1:0]    retired_count,
  output logic [`TRACE_CNT_W-1:0]    flushed_count,
  output logic [`TRACE_CNT_W-1:0]    stall_count,
  output logic [`TRACE_CNT_W-1:0]    drop_count
);

  // Slot view, tracker to lookup
  logic                      slot_valid [5];
  logic [`TRACE_SEQ_W-1:0]   slot_seq [5];
  stage_t                    slot_stage [5];

  // Retire record, tracker to FIFO
  logic                      retire_we;
  logic [`TRACE_SEQ_W-1:0]   rec_seq;
  logic [`TRACE_PC_W-1:0]    rec_pc;
  logic [`TRACE_CYC_W-1:0]   rec_fetch_cyc;
  logic [`TRACE_CYC_W-1:0]   rec_retire_cyc;
  logic [`TRACE_STALL_W-1:0] rec_stalls;

  // Event strobes, tracker to statistics
  logic                      evt_retire;
  logic [1:0]                evt_flush_n;
  logic                      evt_stall;

  pipe_stage_tracker u_tracker (
    .clk, .rst_n, .fetch_valid, .fetch_pc, .stall, .flush,
    .slot_valid, .slot_seq, .slot_stage,
    .retire_we, .rec_seq, .rec_pc, .rec_fetch_cyc, .rec_retire_cyc, .rec_stalls,
    .evt_retire, .evt_flush_n, .evt_stall
  );

  stage_lookup u_lookup (
    .slot_valid, .slot_seq, .slot_stage, .query_seq, .query_hit, .query_stage
  );

  retire_fifo u_fifo (
    .clk, .rst_n,
    .we            (retire_we),
    .wr_seq        (rec_seq),
    .wr_pc         (rec_pc),
    .wr_fetch_cyc  (rec_fetch_cyc),
    .wr_retire_cyc (rec_retire_cyc),
    .wr_stalls     (rec_stalls),
    .rd_en,
    .empty         (ret_empty),
    .rd_seq        (ret_seq),
    .rd_pc         (ret_pc),
    .rd_fetch_cyc  (ret_fetch_cyc),
    .rd_retire_cyc (ret_retire_cyc),
    .rd_stalls     (ret_stalls),
    .drop_count
  );

  trace_stats u_stats (
    .clk, .rst_n, .evt_retire, .evt_flush_n, .evt_stall,
    .retired_count, .flushed_count, .stall_count
  );

endmodule

// ==== dv/tb_clkgen.sv ====
// Testbench clock and reset, 20 ns period
// rst_n is held low for 5 rising edges and released on a falling edge
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #10 clk = ~clk;                  // 20 ns period
  end

  initial begin
    repeat (5) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;             // Release away from the active edge
  end

endmodule

// ==== dv/tb_top.sv ====
// Directed, FIFO fill and random phases checked against a five-slot model of the tracker
// Inputs change on the falling edge and outputs are checked on the next falling edge
`timescale 1ns/1ps
`include "trace_cfg.svh"

module tb_top import trace_pkg::*; #(
  parameter logic [31:0] SEED = 32'h3ec38225
);

  localparam int N_CYCLES   = 530;                       // Sum of all phase lengths
  localparam int WATCHDOG_NS = (N_CYCLES + 5 + 50) * 20;
  localparam int REC_W = `TRACE_SEQ_W + `TRACE_PC_W + 2*`TRACE_CYC_W + `TRACE_STALL_W;

  logic clk, rst_n;
  logic fetch_valid, stall, flush, rd_en;
  logic [`TRACE_PC_W-1:0]    fetch_pc;
  logic [`TRACE_SEQ_W-1:0]   query_seq;
  logic                      query_hit, ret_empty;
  stage_t                    query_stage;
  logic [`TRACE_SEQ_W-1:0]   ret_seq;
  logic [`TRACE_PC_W-1:0]    ret_pc;
  logic [`TRACE_CYC_W-1:0]   ret_fetch_cyc, ret_retire_cyc;
  logic [`TRACE_STALL_W-1:0] ret_stalls;
  logic [`TRACE_CNT_W-1:0]   retired_count, flushed_count, stall_count, drop_count;

  // Reference model slots with slot 0 as IF
  logic                      m_valid [5];
  logic [`TRACE_SEQ_W-1:0]   m_seq   [5];
  logic [`TRACE_PC_W-1:0]    m_pc    [5];
  logic [`TRACE_CYC_W-1:0]   m_fcyc  [5];
  logic [`TRACE_STALL_W-1:0] m_stl   [5];
  logic [`TRACE_SEQ_W-1:0]   m_tag;
  logic [`TRACE_CYC_W-1:0]   m_cyc;
  logic [`TRACE_CNT_W-1:0]   m_retired, m_flushed, m_stalled, m_drops;
  logic [REC_W-1:0]          exp_q [$];                  // Expected FIFO contents
  logic                      killed [256];               // Tags removed by a flush
  logic                      order_check;
  logic [`TRACE_SEQ_W-1:0]   next_seq;
  integer                    seed;
  int                        errors;

  tb_clkgen clkgen0 (.clk, .rst_n);

  pipe_trace_top dut0 (
    .clk, .rst_n, .fetch_valid, .fetch_pc, .stall, .flush, .query_seq, .rd_en,
    .query_hit, .query_stage, .ret_empty, .ret_seq, .ret_pc, .ret_fetch_cyc,
    .ret_retire_cyc, .ret_stalls, .retired_count, .flushed_count, .stall_count,
    .drop_count
  );

  // Counts a wrong value and prints it with the time
  task automatic report_mismatch(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic logic [`TRACE_STALL_W-1:0] stall_add(input logic [`TRACE_STALL_W-1:0] v);
    return (v == '1) ? v : v + 1'b1;
  endfunction

  function automatic stage_t slot_name(input int idx);
    case (idx)
      0:       return FETCH;
      1:       return DECODE;
      2:       return EXECUTE;
      3:       return MEMORY;
      default: return WRITEBACK;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Model of one rising edge from the inputs the testbench drove
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_edge();
    logic held;
    logic acc;
    logic full;
    logic pop;
    held = stall & ~flush;                  // Flush beats stall
    acc  = fetch_valid & (~stall | flush);
    full = (exp_q.size() == `TRACE_FIFO_DEPTH);
    pop  = rd_en && (exp_q.size() > 0);
    if (pop)
      void'(exp_q.pop_front());
    if (m_valid[4]) begin
      m_retired++;
      if (!full || pop)
        exp_q.push_back({m_seq[4], m_pc[4], m_fcyc[4], m_cyc, m_stl[4]});
      else
        m_drops++;                           // Record lost on a full FIFO
    end
    if (flush) begin
      m_flushed += m_valid[0] + m_valid[1];
      if (m_valid[0]) killed[m_seq[0]] = 1'b1;
      if (m_valid[1]) killed[m_seq[1]] = 1'b1;
    end
    if (held && (m_valid[0] || m_valid[1]))
      m_stalled++;
    for (int i = 4; i > 1; i--) begin       // EX..WB always advance
      m_valid[i] = m_valid[i-1];
      m_seq[i]   = m_seq[i-1];
      m_pc[i]    = m_pc[i-1];
      m_fcyc[i]  = m_fcyc[i-1];
      m_stl[i]   = m_stl[i-1];
    end
    m_valid[2] = m_valid[2] & ~stall & ~flush;   // Bubble into EX
    if (flush) begin
      m_valid[1] = 1'b0;
    end else if (!stall) begin
      m_valid[1] = m_valid[0];
      m_seq[1]   = m_seq[0];
      m_pc[1]    = m_pc[0];
      m_fcyc[1]  = m_fcyc[0];
      m_stl[1]   = m_stl[0];
    end else begin
      m_stl[1] = stall_add(m_stl[1]);
    end
    if (acc) begin
      m_valid[0] = 1'b1;
      m_seq[0]   = m_tag;
      m_pc[0]    = fetch_pc;
      m_fcyc[0]  = m_cyc;
      m_stl[0]   = '0;
      killed[m_tag] = 1'b0;
      m_tag++;
    end else if (!held) begin
      m_valid[0] = 1'b0;
    end else begin
      m_stl[0] = stall_add(m_stl[0]);
    end
    m_cyc++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output checks at the falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_outputs();
    logic   hit;
    stage_t stg;
    hit = 1'b0;
    stg = EMPTY;
    for (int i = 4; i >= 0; i--) begin      // Youngest match wins
      if (m_valid[i] && m_seq[i] == query_seq) begin
        hit = 1'b1;
        stg = slot_name(i);
      end
    end
    assert (query_hit == hit && query_stage == stg) else
      report_mismatch($sformatf("lookup tag %0d: hit %0b stage %s, expected %0b %s",
                      query_seq, query_hit, query_stage.name(), hit, stg.name()));
    assert (ret_empty == (exp_q.size() == 0)) else
      report_mismatch($sformatf("ret_empty %0b with %0d records expected",
                      ret_empty, exp_q.size()));
    if (!ret_empty && exp_q.size() > 0) begin
      assert ({ret_seq, ret_pc, ret_fetch_cyc, ret_retire_cyc, ret_stalls} == exp_q[0]) else
        report_mismatch($sformatf("head record tag %0d pc %h cyc %0d/%0d stalls %0d wrong",
                        ret_seq, ret_pc, ret_fetch_cyc, ret_retire_cyc, ret_stalls));
      assert (!killed[ret_seq]) else
        report_mismatch($sformatf("flushed tag %0d reached the FIFO", ret_seq));
      // Latency is only a lower bound once the stall count saturates
      if (ret_stalls != '1) begin
        assert (ret_retire_cyc - ret_fetch_cyc == `TRACE_CYC_W'(5 + ret_stalls)) else
          report_mismatch($sformatf("tag %0d latency %0d with %0d stalls", ret_seq,
                          16'(ret_retire_cyc - ret_fetch_cyc), ret_stalls));
      end
    end
    assert (retired_count == m_retired && flushed_count == m_flushed) else
      report_mismatch($sformatf("retired %0d flushed %0d, expected %0d %0d",
                      retired_count, flushed_count, m_retired, m_flushed));
    assert (stall_count == m_stalled && drop_count == m_drops) else
      report_mismatch($sformatf("stalls %0d drops %0d, expected %0d %0d",
                      stall_count, drop_count, m_stalled, m_drops));
  endtask

  // Drives one cycle at the falling edge, models the rising edge and checks
  task automatic tick(input logic fv, input logic [`TRACE_PC_W-1:0] pc, input logic st,
                      input logic fl, input logic rd, input logic [`TRACE_SEQ_W-1:0] qs);
    fetch_valid = fv;
    fetch_pc    = pc;
    stall       = st;
    flush       = fl;
    rd_en       = rd;
    query_seq   = qs;
    // Popped tags are consecutive in the in-order phase and carry the pc of their tag
    if (order_check && rd && !ret_empty) begin
      assert (ret_seq == next_seq && ret_pc == 32'h1000 + 4 * next_seq) else
        report_mismatch($sformatf("popped tag %0d pc %h, expected tag %0d",
                        ret_seq, ret_pc, next_seq));
      next_seq++;
    end
    @(posedge clk);
    model_edge();
    @(negedge clk);
    check_outputs();
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: simulation ran past %0d ns without finishing", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    integer r;
    fetch_valid = 1'b0;
    fetch_pc    = '0;
    stall       = 1'b0;
    flush       = 1'b0;
    rd_en       = 1'b0;
    query_seq   = '0;
    seed        = SEED;
    errors      = 0;
    order_check = 1'b0;
    next_seq    = '0;
    m_tag       = '0;
    m_cyc       = '0;
    m_retired   = '0;
    m_flushed   = '0;
    m_stalled   = '0;
    m_drops     = '0;
    for (int i = 0; i < 5; i++) begin
      m_valid[i] = 1'b0;
      m_stl[i]   = '0;
    end
    for (int i = 0; i < 256; i++)
      killed[i] = 1'b0;

    @(posedge rst_n);
    check_outputs();                          // Reset state

    // Plain flow without stalls or flushes
    order_check = 1'b1;
    for (int i = 0; i < 20; i++)
      tick(i < 12, 32'h1000 + 4 * i, 1'b0, 1'b0, 1'b1, 8'(i));
    order_check = 1'b0;

    // Stall pairs while fetching
    for (int i = 0; i < 30; i++)
      tick(i < 16, 32'h2000 + 4 * i, (i % 5 == 2) || (i % 5 == 3), 1'b0, 1'b1,
           m_tag - 8'(i % 3));

    // Two flushes with the second one under stall
    for (int i = 0; i < 20; i++)
      tick(i < 10, 32'h3000 + 4 * i, i == 7, (i == 4) || (i == 7), 1'b1, m_tag - 8'd1);

    // FIFO fill with rd_en low and a drain after it
    for (int i = 0; i < 40; i++)
      tick(i < 20, 32'h4000 + 4 * i, 1'b0, 1'b0, 1'b0, m_tag - 8'd2);
    for (int i = 0; i < 20; i++)
      tick(1'b0, '0, 1'b0, 1'b0, 1'b1, m_tag);

    // Random phase
    for (int i = 0; i < 400; i++) begin
      logic fv, st, fl, rd;
      logic [`TRACE_PC_W-1:0] pc;
      r  = $random(seed);
      fv = ((r & 32'h7fffffff) % 100) < 80;
      r  = $random(seed);
      st = ((r & 32'h7fffffff) % 100) < 15;
      r  = $random(seed);
      fl = ((r & 32'h7fffffff) % 100) < 5;
      r  = $random(seed);
      rd = ((r & 32'h7fffffff) % 100) < 70;
      pc = $random(seed);
      r  = $random(seed);
      tick(fv, pc, st, fl, rd, m_tag - 8'((r & 32'h7fffffff) % 8));
    end

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/trace_pkg.sv
verilog/pipe_stage_tracker.sv
verilog/stage_lookup.sv
verilog/retire_fifo.sv
verilog/trace_stats.sv
verilog/pipe_trace_top.sv
dv/tb_clkgen.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the trace monitor testbench
VERILATOR ?= verilator
TOP       ?= tb_top
SEED      ?= 1053000229
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

FILELIST := sources.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
HDRS     := $(wildcard verilog/*.svh)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-GSEED=$(SEED) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TEST FAIL" $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
